// File: vlog.f
+incdir+hdl
+incdir+verif
hdl/mask_gen_pkg.sv
hdl/raster_if.sv
hdl/raster_scan.sv
hdl/window_mask.sv
hdl/mask_gen_top.sv
verif/tb_mask_gen.sv

// File: Bender.yml
package:
  name: mask_gen

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mask_gen_pkg.sv
      - hdl/raster_if.sv
      - hdl/raster_scan.sv
      - hdl/window_mask.sv
      - hdl/mask_gen_top.sv
  - target: test
    include_dirs:
      - hdl
      - verif
    files:
      - verif/tb_mask_gen.sv

// File: verif/mask_ref.svh
`ifndef MASK_REF_SVH
`define MASK_REF_SVH

// expected channel mask of one pixel, OR over the routed windows
function automatic chan_bmp_t exp_mask(input int col, input int row, input win_cfg_arr_t cfg);
	chan_bmp_t mask;
	int        w;
	int        left;
	int        top;
	int        right;
	int        bottom;
	mask = '0;
	for (w = 0; w < `MG_WIN_NUM; w++) begin
		left   = cfg[w].left;
		top    = cfg[w].top;
		right  = left + int'(cfg[w].width);
		bottom = top + int'(cfg[w].height);
		if (col >= left && col < right && row >= top && row < bottom) begin
			mask = mask | cfg[w].dst_bmp;
		end
	end
	return mask;
endfunction

// mask above, start of frame in bit 0
function automatic logic [`MG_WIN_NUM:0] exp_tuser(input int col, input int row,
		input win_cfg_arr_t cfg);
	logic sof;
	sof = (col == 0) && (row == 0);
	return {exp_mask(col, row, cfg), sof};
endfunction

// grey level falls by one per column, top byte fixed
function automatic logic [`MG_PIXEL_WIDTH-1:0] exp_data(input int col, input bit var_data);
	logic [7:0] grey;
	grey = 8'(255 - col);
	if (!var_data) begin
		return '0;
	end
	return {8'hff, grey, grey, grey};
endfunction

function automatic logic exp_last(input int col, input int width);
	return col == width - 1;
endfunction

`endif

// File: verif/tb_mask_gen.sv
`timescale 1ns/1ps
`include "mask_gen_defs.svh"

module tb_mask_gen #(
	parameter int unsigned TB_EXT_FSYNC = 1,
	parameter int unsigned TB_VAR_DATA  = 1
);
	import mask_gen_pkg::*;

	`include "mask_ref.svh"

	localparam int TB_WIDTH  = 16;
	localparam int TB_HEIGHT = 6;
	localparam int NUM_CFG   = 6;
	localparam int TIMEOUT   = 2000;

	logic                       clk;
	logic                       resetn;
	logic                       fsync_i;
	col_t                       width_i;
	row_t                       height_i;
	win_cfg_arr_t               win_cfg;
	logic                       m_axis_tvalid_o;
	logic [`MG_PIXEL_WIDTH-1:0] m_axis_tdata_o;
	logic [`MG_WIN_NUM:0]       m_axis_tuser_o;
	logic                       m_axis_tlast_o;
	logic                       m_axis_tready_i;

	// comparator state
	int                   col;
	int                   row;
	int                   rst_cycles;
	int                   live_cycles;
	int                   frames_seen;
	logic                 frame_end;
	logic                 stalled;
	logic [`MG_WIN_NUM:0] exp_tu;

	mask_gen_top #(
		.EXT_FSYNC (TB_EXT_FSYNC),
		.VAR_DATA  (TB_VAR_DATA)
	) dut_i (
		.clk             (clk),
		.resetn          (resetn),
		.fsync_i         (fsync_i),
		.width_i         (width_i),
		.height_i        (height_i),
		.win_cfg_i       (win_cfg),
		.m_axis_tvalid_o (m_axis_tvalid_o),
		.m_axis_tdata_o  (m_axis_tdata_o),
		.m_axis_tuser_o  (m_axis_tuser_o),
		.m_axis_tlast_o  (m_axis_tlast_o),
		.m_axis_tready_i (m_axis_tready_i)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_bmp(input string name, input chan_bmp_t got, input chan_bmp_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Error: %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Error: %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_data(input string name, input logic [`MG_PIXEL_WIDTH-1:0] got,
			input logic [`MG_PIXEL_WIDTH-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Error: %s expected %h got %h", name, exp, got));
		end
	endtask

	function automatic win_cfg_t make_win(input int left, input int top, input int width,
			input int height, input int dst);
		win_cfg_t w;
		w.left    = col_t'(left);
		w.top     = row_t'(top);
		w.width   = col_t'(width);
		w.height  = row_t'(height);
		w.dst_bmp = chan_bmp_t'(dst);
		return w;
	endfunction

	function automatic win_cfg_arr_t make_cfg(input int n);
		win_cfg_arr_t cfg;
		int           w;
		int           left;
		int           top;
		cfg = '0;
		if (n == 0) begin
			// full-width band on both channels overlapped by a window on channel 0
			cfg[0] = make_win(0, 0, TB_WIDTH, 2, 3);
			cfg[1] = make_win(4, 1, 5, 4, 1);
		end else if (n == 1) begin
			// unrouted window and one in the bottom right corner
			cfg[0] = make_win(2, 2, 6, 3, 0);
			cfg[1] = make_win(10, 3, 6, 3, 2);
		end else begin
			for (w = 0; w < `MG_WIN_NUM; w++) begin
				left   = $urandom % TB_WIDTH;
				top    = $urandom % TB_HEIGHT;
				cfg[w] = make_win(left, top, $urandom % (TB_WIDTH + 1 - left),
					$urandom % (TB_HEIGHT + 1 - top), $urandom);
			end
		end
		return cfg;
	endfunction

	// called 2 ns after a rising edge
	task automatic reset_dut(input win_cfg_arr_t cfg);
		resetn  = 1'b0;
		win_cfg = cfg;
		repeat (16) @(posedge clk);
		#2;
		resetn = 1'b1;
	endtask

	task automatic wait_frame(input int target);
		int cnt;
		cnt = 0;
		while (frames_seen < target) begin
			@(posedge clk);
			#2;
			cnt++;
			if (cnt > TIMEOUT) begin
				abort_run("timeout while waiting for the end of a frame");
			end
		end
	endtask

	task automatic run_sync_frame();
		int idle;
		idle = 1 + ($urandom % 4);
		repeat (idle) begin
			@(negedge clk);
			check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
		end
		@(posedge clk);
		#2;
		fsync_i = 1'b1;
		// still idle in the fsync cycle itself
		@(negedge clk);
		check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
		@(posedge clk);
		#2;
		fsync_i = 1'b0;
		@(negedge clk);
		check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b1);
		wait_frame(frames_seen + 1);
	endtask

	// random back-pressure with about 70 % ready
	always @(posedge clk) begin
		#2;
		m_axis_tready_i = ($urandom % 10) < 7;
	end

	// beats seen at mid-cycle transfer on the next rising edge
	always @(negedge clk) begin
		if (!resetn) begin
			if (rst_cycles > 0) begin
				check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
				check_flag("m_axis_tuser_o[0]", m_axis_tuser_o[0], 1'b0);
				check_bmp("m_axis_tuser_o mask", m_axis_tuser_o[`MG_WIN_NUM:1], '0);
			end
			rst_cycles++;
			live_cycles = 0;
			col         = 0;
			row         = 0;
			frame_end   = 1'b0;
			stalled     = 1'b0;
		end else begin
			rst_cycles = 0;
			if (TB_EXT_FSYNC == 0) begin
				check_flag("m_axis_tvalid_o", m_axis_tvalid_o, live_cycles != 0);
			end else if (frame_end) begin
				check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
			end else if (stalled) begin
				check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b1);
			end
			frame_end = 1'b0;
			if (m_axis_tvalid_o) begin
				exp_tu = exp_tuser(col, row, win_cfg);
				check_flag("m_axis_tlast_o", m_axis_tlast_o, exp_last(col, TB_WIDTH));
				check_flag("m_axis_tuser_o[0]", m_axis_tuser_o[0], exp_tu[0]);
				check_bmp("m_axis_tuser_o mask", m_axis_tuser_o[`MG_WIN_NUM:1],
					exp_tu[`MG_WIN_NUM:1]);
				check_data("m_axis_tdata_o", m_axis_tdata_o, exp_data(col, TB_VAR_DATA != 0));
				if (m_axis_tready_i) begin
					if (col == TB_WIDTH - 1) begin
						col = 0;
						if (row == TB_HEIGHT - 1) begin
							row       = 0;
							frame_end = 1'b1;
							frames_seen++;
						end else begin
							row++;
						end
					end else begin
						col++;
					end
				end
			end
			stalled = m_axis_tvalid_o & ~m_axis_tready_i;
			live_cycles++;
		end
	end

	initial begin
		int n;
		void'($urandom(64));
		clk             = 1'b0;
		resetn          = 1'b0;
		fsync_i         = 1'b0;
		width_i         = col_t'(TB_WIDTH);
		height_i        = row_t'(TB_HEIGHT);
		win_cfg         = '0;
		m_axis_tready_i = 1'b0;
		frames_seen     = 0;
		rst_cycles      = 0;
		live_cycles     = 0;

		for (n = 0; n < NUM_CFG; n++) begin
			reset_dut(make_cfg(n));
			if (TB_EXT_FSYNC != 0) begin
				// two fsync frames per window setup
				run_sync_frame();
				run_sync_frame();
			end else begin
				wait_frame(frames_seen + 2);
			end
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: hdl/mask_gen_top.sv
`timescale 1ns/1ps
`include "mask_gen_defs.svh"

module mask_gen_top #(
	parameter int unsigned EXT_FSYNC = 0,
	parameter int unsigned VAR_DATA  = 0
) (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       fsync_i,
	input  mask_gen_pkg::col_t         width_i,
	input  mask_gen_pkg::row_t         height_i,
	input  mask_gen_pkg::win_cfg_arr_t win_cfg_i,
	output logic                       m_axis_tvalid_o,
	output logic [`MG_PIXEL_WIDTH-1:0] m_axis_tdata_o,
	output logic [`MG_WIN_NUM:0]       m_axis_tuser_o,
	output logic                       m_axis_tlast_o,
	input  logic                       m_axis_tready_i
);
	import mask_gen_pkg::*;

	chan_bmp_t chan_mask;
	logic      sof;

	// scanner position shared with the matcher
	raster_if rast_if ();

	raster_scan #(
		.EXT_FSYNC (EXT_FSYNC),
		.VAR_DATA  (VAR_DATA)
	) scan_i (
		.clk             (clk),
		.resetn          (resetn),
		.fsync_i         (fsync_i),
		.width_i         (width_i),
		.height_i        (height_i),
		.rast            (rast_if.scan),
		.m_axis_tvalid_o (m_axis_tvalid_o),
		.m_axis_tdata_o  (m_axis_tdata_o),
		.sof_o           (sof),
		.m_axis_tlast_o  (m_axis_tlast_o),
		.m_axis_tready_i (m_axis_tready_i)
	);

	window_mask mask_i (
		.clk         (clk),
		.resetn      (resetn),
		.rast        (rast_if.mask),
		.win_cfg_i   (win_cfg_i),
		.chan_mask_o (chan_mask)
	);

	// bit 0 start of frame, channel mask above it
	assign m_axis_tuser_o = {chan_mask, sof};

endmodule

// File: hdl/window_mask.sv
`timescale 1ns/1ps
`include "mask_gen_defs.svh"

module window_mask (
	input  logic                       clk,
	input  logic                       resetn,
	raster_if.mask                     rast,
	input  mask_gen_pkg::win_cfg_arr_t win_cfg_i,
	output mask_gen_pkg::chan_bmp_t    chan_mask_o
);
	import mask_gen_pkg::*;

	// one bit per window, both flags set
	logic [`MG_WIN_NUM-1:0] win_hit;

	// per channel, the windows routed to it
	chan_bmp_t src_bmp [`MG_WIN_NUM];

	genvar i;
	genvar j;

	generate
		for (i = 0; i < `MG_WIN_NUM; i = i + 1) begin : g_win
			col_t col_end;
			row_t row_end;
			logic col_in_q;
			logic row_in_q;

			assign col_end = win_cfg_i[i].left + win_cfg_i[i].width;
			assign row_end = win_cfg_i[i].top + win_cfg_i[i].height;

			// end compare first so an empty window never opens
			always_ff @(posedge clk) begin
				if (!resetn) begin
					col_in_q <= 1'b0;
				end else if (rast.cupdate) begin
					if (rast.cidx_next == col_end) begin
						col_in_q <= 1'b0;
					end else if (rast.cidx_next == win_cfg_i[i].left) begin
						col_in_q <= 1'b1;
					end else if (rast.clast) begin
						// window reaching the right edge
						col_in_q <= 1'b0;
					end
				end
			end

			always_ff @(posedge clk) begin
				if (!resetn) begin
					row_in_q <= 1'b0;
				end else if (rast.rupdate) begin
					if (rast.ridx_next == row_end) begin
						row_in_q <= 1'b0;
					end else if (rast.ridx_next == win_cfg_i[i].top) begin
						row_in_q <= 1'b1;
					end else if (rast.rlast) begin
						row_in_q <= 1'b0;
					end
				end
			end

			assign win_hit[i] = col_in_q & row_in_q;
		end

		// transpose of the destination bitmaps
		for (i = 0; i < `MG_WIN_NUM; i = i + 1) begin : g_chan
			for (j = 0; j < `MG_WIN_NUM; j = j + 1) begin : g_src
				assign src_bmp[i][j] = win_cfg_i[j].dst_bmp[i];
			end

			assign chan_mask_o[i] = |(win_hit & src_bmp[i]);
		end
	endgenerate

endmodule

// File: hdl/raster_scan.sv
`timescale 1ns/1ps
`include "mask_gen_defs.svh"

module raster_scan #(
	parameter int unsigned EXT_FSYNC = 0,
	parameter int unsigned VAR_DATA  = 0
) (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       fsync_i,
	input  mask_gen_pkg::col_t         width_i,
	input  mask_gen_pkg::row_t         height_i,
	raster_if.scan                     rast,
	output logic                       m_axis_tvalid_o,
	output logic [`MG_PIXEL_WIDTH-1:0] m_axis_tdata_o,
	output logic                       sof_o,
	output logic                       m_axis_tlast_o,
	input  logic                       m_axis_tready_i
);
	import mask_gen_pkg::*;

	// look-ahead position and its next-is-last flags
	col_t cidx_next;
	row_t ridx_next;
	logic clast_next;
	logic rlast_next;

	// flags of the presented beat
	logic clast;
	logic rlast;
	logic sof_q;

	logic cupdate;
	logic rupdate;
	logic tvalid_q;
	logic plast;
	logic xfer;

	assign plast = clast & rlast;
	assign xfer  = tvalid_q & m_axis_tready_i;

	generate
		if (EXT_FSYNC != 0) begin : g_ext_sync
			// frame boundary waits for fsync, otherwise follow ready
			assign cupdate = plast ? fsync_i : m_axis_tready_i;
			assign rupdate = clast & (rlast ? fsync_i : m_axis_tready_i);

			always_ff @(posedge clk) begin
				if (!resetn) begin
					tvalid_q <= 1'b0;
				end else if (fsync_i) begin
					tvalid_q <= 1'b1;
				end else if (xfer && plast) begin
					tvalid_q <= 1'b0;
				end
			end
		end else begin : g_free_run
			// load a new beat when the output slot is empty or drains
			assign cupdate = ~tvalid_q | m_axis_tready_i;
			assign rupdate = clast & cupdate;

			always_ff @(posedge clk) begin
				if (!resetn) begin
					tvalid_q <= 1'b0;
				end else begin
					tvalid_q <= 1'b1;
				end
			end
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cidx_next  <= '0;
			clast_next <= (width_i == col_t'(1));
		end else if (cupdate) begin
			if (clast_next) begin
				cidx_next <= '0;
			end else begin
				cidx_next <= cidx_next + col_t'(1);
			end
			clast_next <= (width_i == col_t'(1)) || (cidx_next == width_i - col_t'(2));
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ridx_next  <= '0;
			rlast_next <= (height_i == row_t'(1));
		end else if (rupdate) begin
			if (rlast_next) begin
				ridx_next <= '0;
			end else begin
				ridx_next <= ridx_next + row_t'(1);
			end
			rlast_next <= (height_i == row_t'(1)) || (ridx_next == height_i - row_t'(2));
		end
	end

	// both set so the first beat opens a frame
	always_ff @(posedge clk) begin
		if (!resetn) begin
			clast <= 1'b1;
		end else if (cupdate) begin
			clast <= clast_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rlast <= 1'b1;
		end else if (rupdate) begin
			rlast <= rlast_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			sof_q <= 1'b0;
		end else if (cupdate) begin
			sof_q <= (cidx_next == '0) && (ridx_next == '0);
		end
	end

	generate
		if (VAR_DATA != 0) begin : g_var_data
			logic [7:0] grey_q;

			// grey level falls along the line
			always_ff @(posedge clk) begin
				if (!resetn) begin
					grey_q <= 8'hff;
				end else if (xfer) begin
					grey_q <= clast ? 8'hff : grey_q - 8'd1;
				end
			end

			assign m_axis_tdata_o = {8'hff, grey_q, grey_q, grey_q};
		end else begin : g_zero_data
			assign m_axis_tdata_o = '0;
		end
	endgenerate

	assign m_axis_tvalid_o = tvalid_q;
	assign m_axis_tlast_o  = clast;
	assign sof_o           = sof_q;

	assign rast.cupdate   = cupdate;
	assign rast.rupdate   = rupdate;
	assign rast.cidx_next = cidx_next;
	assign rast.ridx_next = ridx_next;
	assign rast.clast     = clast;
	assign rast.rlast     = rlast;

endmodule

// File: hdl/raster_if.sv
`timescale 1ns/1ps

interface raster_if ();
	import mask_gen_pkg::*;

	logic cupdate;
	logic rupdate;
	// position of the beat presented after the next update
	col_t cidx_next;
	row_t ridx_next;
	// flags of the beat presented now
	logic clast;
	logic rlast;

	modport scan (
		output cupdate,
		output rupdate,
		output cidx_next,
		output ridx_next,
		output clast,
		output rlast
	);

	modport mask (
		input cupdate,
		input rupdate,
		input cidx_next,
		input ridx_next,
		input clast,
		input rlast
	);

endinterface

// File: hdl/mask_gen_pkg.sv
`include "mask_gen_defs.svh"

package mask_gen_pkg;

	// raster coordinates
	typedef logic [`MG_IMG_WBITS-1:0] col_t;
	typedef logic [`MG_IMG_HBITS-1:0] row_t;

	// one bit per output channel
	typedef logic [`MG_WIN_NUM-1:0] chan_bmp_t;

	// one rectangle, right/bottom edges are exclusive
	typedef struct packed {
		col_t      left;
		row_t      top;
		col_t      width;
		row_t      height;
		chan_bmp_t dst_bmp;
	} win_cfg_t;

	typedef win_cfg_t [`MG_WIN_NUM-1:0] win_cfg_arr_t;

endpackage

// File: hdl/mask_gen_defs.svh
`ifndef MASK_GEN_DEFS_SVH
`define MASK_GEN_DEFS_SVH

// number of windows, also the number of output channels (at most 8)
`define MG_WIN_NUM 2

// stream data width
`define MG_PIXEL_WIDTH 32

// coordinate widths
`define MG_IMG_WBITS 12
`define MG_IMG_HBITS 12

`endif
